// File: hw/dispatch_cfg_pkg.sv
package dispatch_cfg_pkg;

  // ----------------------------------------
  // Structural sizes
  // ----------------------------------------

  // Number of parallel lanes behind the dispatcher
  localparam int NUM_LANES = 2;

  // ----------------------------------------
  // Datapath widths
  // ----------------------------------------

  // Width of the data symbol carried by each job
  localparam int SYMBOL_WIDTH = 8;

  // Running sum of one lane, wraps modulo 2**SUM_WIDTH
  localparam int SUM_WIDTH = 16;

  // Per-lane job counter, wraps on overflow
  localparam int COUNT_WIDTH = 8;

endpackage : dispatch_cfg_pkg

// File: hw/dispatch_types_pkg.sv
package dispatch_types_pkg;
  import dispatch_cfg_pkg::*;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic [SYMBOL_WIDTH-1:0] symbol_t;
  // Binary lane select, wide enough to name every lane
  typedef logic [$clog2(NUM_LANES)-1:0] lane_sel_t;
  typedef logic [SUM_WIDTH-1:0] sum_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // Job opcode, the two upper codes are unused
  typedef enum logic [1:0] {
    OP_ADD   = 2'd0,
    OP_CLEAR = 2'd1
  } op_e;

  // ----------------------------------------
  // Records
  // ----------------------------------------

  // One job as it enters the dispatcher, 11 bits
  typedef struct packed {
    lane_sel_t lane;
    op_e       op;
    symbol_t   symbol;
  } job_t;

  // One lane result as it leaves through the merger, 25 bits
  typedef struct packed {
    lane_sel_t lane;
    count_t    count;
    sum_t      sum;
  } result_t;

endpackage : dispatch_types_pkg

// File: hw/job_dispatcher.sv
`timescale 1ns/1ps

module job_dispatcher
  import dispatch_cfg_pkg::*, dispatch_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_req,
  input  job_t                 in_job,
  output logic                 in_ack,
  output job_t                 lane_job,
  output logic [NUM_LANES-1:0] lane_req,
  input  logic [NUM_LANES-1:0] lane_ack
);

  // SEND holds the lane request, RELEASE and DONE hold in_ack
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    RELEASE,
    DONE
  } state_e;

  state_e state;
  job_t   job_q;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (in_req) begin
            state <= SEND;
          end
        end
        // Lane request drops and in_ack rises on the same edge
        SEND: begin
          if (lane_ack[job_q.lane]) begin
            state <= RELEASE;
          end
        end
        RELEASE: begin
          if (!in_req) begin
            state <= DONE;
          end
        end
        // The lane must finish its own return to zero first
        DONE: begin
          if (!lane_ack[job_q.lane]) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Job payload is captured once per transfer, while still idle
  always_ff @(posedge clk) begin
    if (state == IDLE && in_req) begin
      job_q <= in_job;
    end
  end

  // ----------------------------------------
  // Binary select demux
  // ----------------------------------------

  // Every lane sees the same job, only the selected one gets a request
  assign lane_job = job_q;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_req[i] = (state == SEND) && (job_q.lane == lane_sel_t'(i));
    end
  end

  assign in_ack = (state == RELEASE) || (state == DONE);

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_lane_req_onehot0: assert property (@(posedge clk) disable iff (rst)
    $onehot0(lane_req))
    else $error("more than one lane request is active");

  a_lane_req_in_send: assert property (@(posedge clk) disable iff (rst)
    (lane_req != '0) |-> (state == SEND))
    else $error("lane request seen outside of the send phase");

  // The sender may only change the job once its request has dropped
  a_in_job_stable: assert property (@(posedge clk) disable iff (rst)
    (in_req && !in_ack) |=> (!in_req || $stable(in_job)))
    else $error("input job changed while its request was pending");

endmodule : job_dispatcher

// File: hw/lane_accumulator.sv
`timescale 1ns/1ps

module lane_accumulator
  import dispatch_cfg_pkg::*, dispatch_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    job_req,
  input  job_t    job,
  output logic    job_ack,
  output logic    res_req,
  output result_t res,
  input  logic    res_ack
);

  // ACK answers the job port, OFFER and RELEASE run the result port
  typedef enum logic [1:0] {
    IDLE,
    ACK,
    OFFER,
    RELEASE
  } state_e;

  state_e    state;
  sum_t      sum_q;
  count_t    count_q;
  lane_sel_t lane_q;
  sum_t      sum_next;

  // ----------------------------------------
  // Sum update
  // ----------------------------------------

  // The symbol is zero extended before it is added
  always_comb begin
    case (job.op)
      OP_CLEAR: sum_next = '0;
      default:  sum_next = sum_q + {{(SUM_WIDTH-SYMBOL_WIDTH){1'b0}}, job.symbol};
    endcase
  end

  // ----------------------------------------
  // Control FSM and accumulator
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      sum_q   <= '0;
      count_q <= '0;
    end else begin
      case (state)
        // A job is only taken here, so one result at most is held
        IDLE: begin
          if (job_req) begin
            sum_q   <= sum_next;
            count_q <= count_q + 1'b1;
            state   <= ACK;
          end
        end
        ACK: begin
          if (!job_req) begin
            state <= OFFER;
          end
        end
        // Stays here as long as the merger holds off
        OFFER: begin
          if (res_ack) begin
            state <= RELEASE;
          end
        end
        RELEASE: begin
          if (!res_ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Lane tag of the last job, only read together with the result
  always_ff @(posedge clk) begin
    if (state == IDLE && job_req) begin
      lane_q <= job.lane;
    end
  end

  // ----------------------------------------
  // Port outputs
  // ----------------------------------------
  assign job_ack   = (state == ACK);
  assign res_req   = (state == OFFER);
  assign res.lane  = lane_q;
  assign res.count = count_q;
  assign res.sum   = sum_q;

  // A new job must never be acked before the previous result left
  a_no_ack_while_offer: assert property (@(posedge clk) disable iff (rst)
    $rose(job_ack) |-> (!res_req && !$past(res_req)))
    else $error("job acked while a result was still offered");

endmodule : lane_accumulator

// File: hw/result_merger.sv
`timescale 1ns/1ps

module result_merger
  import dispatch_cfg_pkg::*, dispatch_types_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [NUM_LANES-1:0]    res_req,
  input  result_t [NUM_LANES-1:0] res_val,
  output logic [NUM_LANES-1:0]    res_ack,
  output logic                    out_req,
  output result_t                 out_result,
  input  logic                    out_ack
);

  // The output handshake completes fully before the lane is acked
  typedef enum logic [2:0] {
    IDLE,
    OUT_REQ,
    OUT_WAIT,
    LANE_ACK,
    LANE_WAIT
  } state_e;

  state_e    state;
  lane_sel_t last_q;
  lane_sel_t other;
  lane_sel_t grant;
  result_t   result_q;

  // ----------------------------------------
  // Round-robin pick
  // ----------------------------------------

  // The lane not served last wins when both are pending
  assign other = lane_sel_t'(last_q + 1'b1);

  always_comb begin
    grant = last_q;
    if (res_req[other]) begin
      grant = other;
    end
  end

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      // Last grant at lane 1 puts lane 0 first after reset
      last_q <= lane_sel_t'(NUM_LANES - 1);
    end else begin
      case (state)
        IDLE: begin
          if (res_req != '0) begin
            last_q <= grant;
            state  <= OUT_REQ;
          end
        end
        OUT_REQ: begin
          if (out_ack) begin
            state <= OUT_WAIT;
          end
        end
        OUT_WAIT: begin
          if (!out_ack) begin
            state <= LANE_ACK;
          end
        end
        // Hold the lane ack until that lane withdraws its request
        LANE_ACK: begin
          if (!res_req[last_q]) begin
            state <= LANE_WAIT;
          end
        end
        // One settle cycle lets the lane see its ack low
        LANE_WAIT: state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  // Output record is loaded only when a new grant is made
  always_ff @(posedge clk) begin
    if (state == IDLE && res_req != '0) begin
      result_q <= res_val[grant];
    end
  end

  // ----------------------------------------
  // Port outputs
  // ----------------------------------------
  assign out_req    = (state == OUT_REQ);
  assign out_result = result_q;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      res_ack[i] = (state == LANE_ACK) && (last_q == lane_sel_t'(i));
    end
  end

  a_res_ack_onehot0: assert property (@(posedge clk) disable iff (rst)
    $onehot0(res_ack))
    else $error("more than one lane acked at once");

  a_out_result_stable: assert property (@(posedge clk) disable iff (rst)
    out_req |=> (!out_req || $stable(out_result)))
    else $error("output result changed while its request was high");

endmodule : result_merger

// File: hw/dispatch_top.sv
`timescale 1ns/1ps

module dispatch_top
  import dispatch_cfg_pkg::*, dispatch_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_req,
  input  job_t    in_job,
  output logic    in_ack,
  output logic    out_req,
  output result_t out_result,
  input  logic    out_ack
);

  // ----------------------------------------
  // Dispatcher to lanes
  // ----------------------------------------
  job_t                 lane_job;
  logic [NUM_LANES-1:0] lane_req;
  logic [NUM_LANES-1:0] lane_ack;

  // ----------------------------------------
  // Lanes to merger
  // ----------------------------------------
  logic [NUM_LANES-1:0]    res_req;
  result_t [NUM_LANES-1:0] res_val;
  logic [NUM_LANES-1:0]    res_ack;

  job_dispatcher u_dispatcher (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_job   (in_job),
    .in_ack   (in_ack),
    .lane_job (lane_job),
    .lane_req (lane_req),
    .lane_ack (lane_ack)
  );

  // Both lanes see the same job bus, the request picks the one that acts
  lane_accumulator u_lane0 (
    .clk     (clk),
    .rst     (rst),
    .job_req (lane_req[0]),
    .job     (lane_job),
    .job_ack (lane_ack[0]),
    .res_req (res_req[0]),
    .res     (res_val[0]),
    .res_ack (res_ack[0])
  );

  lane_accumulator u_lane1 (
    .clk     (clk),
    .rst     (rst),
    .job_req (lane_req[1]),
    .job     (lane_job),
    .job_ack (lane_ack[1]),
    .res_req (res_req[1]),
    .res     (res_val[1]),
    .res_ack (res_ack[1])
  );

  result_merger u_merger (
    .clk        (clk),
    .rst        (rst),
    .res_req    (res_req),
    .res_val    (res_val),
    .res_ack    (res_ack),
    .out_req    (out_req),
    .out_result (out_result),
    .out_ack    (out_ack)
  );

endmodule : dispatch_top

// File: tests/dispatch_tb.sv
`timescale 1ns/1ps

module dispatch_tb
  import dispatch_cfg_pkg::*, dispatch_types_pkg::*;
();

  localparam int NUM_JOBS       = 200;
  localparam int TIMEOUT_CYCLES = NUM_JOBS * 40;

  // One expected result, tagged with whether its job cleared the sum
  typedef struct packed {
    logic    clear;
    result_t res;
  } expect_t;

  logic    clk;
  logic    rst;
  logic    in_req;
  job_t    in_job;
  logic    in_ack;
  logic    out_req;
  result_t out_result;
  logic    out_ack;

  int errors    = 0;
  int checks    = 0;
  int n_results = 0;
  int cycles    = 0;

  // Reference model state, one sum and count per lane
  sum_t    model_sum   [NUM_LANES];
  count_t  model_count [NUM_LANES];
  expect_t exp_q0 [$];
  expect_t exp_q1 [$];

  // Previous samples for the handshake monitor
  logic    prev_in_ack     = 1'b0;
  logic    prev_out_req    = 1'b0;
  logic    prev_out_ack    = 1'b0;
  result_t prev_out_result = '0;

  dispatch_top u_dispatch_top (
    .clk        (clk),
    .rst        (rst),
    .in_req     (in_req),
    .in_job     (in_job),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_result (out_result),
    .out_ack    (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // Checks and reporting
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic end_run();
    $display("Checks run: %0d, errors: %0d, results seen: %0d", checks, errors, n_results);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Applies the job to its lane and queues the result that lane must give
  task automatic record_job(input job_t j);
    expect_t e;
    if (j.op == OP_CLEAR) begin
      model_sum[j.lane] = '0;
    end else begin
      model_sum[j.lane] = model_sum[j.lane] + j.symbol;
    end
    model_count[j.lane] = model_count[j.lane] + 1'b1;
    e.clear     = (j.op == OP_CLEAR);
    e.res.lane  = j.lane;
    e.res.count = model_count[j.lane];
    e.res.sum   = model_sum[j.lane];
    if (j.lane == 0) begin
      exp_q0.push_back(e);
    end else begin
      exp_q1.push_back(e);
    end
  endtask

  // Matching is per lane, results of different lanes may interleave
  task automatic check_result(input result_t r);
    expect_t e;
    logic    found;
    found = 1'b0;
    if (r.lane == 0 && exp_q0.size() > 0) begin
      e     = exp_q0.pop_front();
      found = 1'b1;
    end else if (r.lane == 1 && exp_q1.size() > 0) begin
      e     = exp_q1.pop_front();
      found = 1'b1;
    end
    n_results++;
    if (!found) begin
      errors++;
      $display("A result for lane %0d arrived with no job pending on that lane", r.lane);
    end else begin
      check_value($sformatf("lane%0d_count", r.lane), e.res.count, r.count);
      check_value($sformatf("lane%0d_sum", r.lane), e.res.sum, r.sum);
      if (e.clear) begin
        check_value($sformatf("lane%0d_sum_after_clear", r.lane), 0, r.sum);
      end
    end
  endtask

  // ----------------------------------------
  // Input driver
  // ----------------------------------------

  // Four-phase transfer of one job, entered and left on a rising edge
  task automatic send_job(input job_t j);
    in_job <= j;
    in_req <= 1'b1;
    do @(posedge clk); while (!in_ack);
    in_req <= 1'b0;
    do @(posedge clk); while (in_ack);
  endtask

  initial begin
    job_t j;
    void'($urandom(13));
    rst     = 1'b1;
    in_req  = 1'b0;
    in_job  = '0;
    out_ack = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      model_sum[i]   = '0;
      model_count[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("reset_in_ack", 0, in_ack);
    check_value("reset_out_req", 0, out_req);
    for (int i = 0; i < NUM_JOBS; i++) begin
      // Roughly one job in eight clears its lane
      j.op     = (($urandom % 8) == 0) ? OP_CLEAR : OP_ADD;
      j.lane   = lane_sel_t'($urandom % NUM_LANES);
      j.symbol = symbol_t'($urandom);
      record_job(j);
      send_job(j);
    end
    while (n_results < NUM_JOBS) @(posedge clk);
    // Extra idle cycles so a duplicated result would still show up
    repeat (20) @(posedge clk);
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      errors++;
      $display("Results are missing at the end, lane 0 owes %0d and lane 1 owes %0d",
               exp_q0.size(), exp_q1.size());
    end
    check_value("result_count", NUM_JOBS, n_results);
    end_run();
  end

  // ----------------------------------------
  // Output responder
  // ----------------------------------------
  initial begin
    int unsigned delay;
    forever begin
      @(posedge clk);
      if (!rst && out_req) begin
        check_result(out_result);
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        out_ack <= 1'b1;
        do @(posedge clk); while (out_req);
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        out_ack <= 1'b0;
      end
    end
  end

  // Port handshake order, sampled on the same edges as the driver
  always @(posedge clk) begin
    if (!rst) begin
      if (in_ack && !prev_in_ack && !in_req) begin
        errors++;
        $display("in_ack rose while in_req was low");
      end
      if (prev_out_req && !out_req && !prev_out_ack) begin
        errors++;
        $display("out_req dropped before out_ack was raised");
      end
      if (prev_out_req && out_req && out_result !== prev_out_result) begin
        errors++;
        $display("out_result changed while out_req was high");
      end
    end
    prev_in_ack     = in_ack;
    prev_out_req    = out_req;
    prev_out_ack    = out_ack;
    prev_out_result = out_result;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end_run();
  end

endmodule : dispatch_tb

// File: tb.f
hw/dispatch_cfg_pkg.sv
hw/dispatch_types_pkg.sv
hw/job_dispatcher.sv
hw/lane_accumulator.sv
hw/result_merger.sv
hw/dispatch_top.sv
tests/dispatch_tb.sv
